// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_rv_exec_core
FILELIST := compile.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(BUILD)

// File: compile.f
design/rv_core_pkg.sv
design/rv_regfile_if.sv
design/rv_uop_if.sv
design/rv_register_file.sv
design/rv_decoder.sv
design/rv_execute_unit.sv
design/rv_exec_core.sv
testbench/tb_rv_exec_core.sv

// File: design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // ------------------------------------------------------------------
    // Widths and sizes.
    // ------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // Register a0 drives the status pin.
    localparam int A0_INDEX = 10;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // ------------------------------------------------------------------
    // Encodings.
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate funct7 selects SUB and SRA.
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // ALU operation; PASS_B serves LUI.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/rv_decoder.sv
`default_nettype none

module rv_decoder (
    input  rv_core_pkg::instr_t  i_instr,
    input  logic                 i_instr_valid,
    rv_regfile_if.decoder        rf,
    rv_uop_if.decoder            uop
);
    import rv_core_pkg::*;

    // ------------------------------------------------------------------
    // Instruction fields.
    // ------------------------------------------------------------------
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      imm_i;
    xlen_t      imm_u;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];
    assign funct7 = i_instr[31:25];
    assign funct6 = i_instr[31:26];

    // Immediates, both sign extended to XLEN.
    assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {{(XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};

    // ------------------------------------------------------------------
    // Operation select and legality.
    // ------------------------------------------------------------------
    alu_op_e   alu_op;
    logic      use_imm;
    xlen_t     imm;
    logic      legal;
    reg_addr_t rs1_sel;

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        imm     = '0;
        legal   = 1'b0;
        rs1_sel = rs1;
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == FUNCT7_BASE) ||
                        (funct7 == FUNCT7_ALT &&
                         (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                case (funct3)
                    F3_ADD_SUB: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    default:    alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                imm     = imm_i;
                legal   = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLL: begin
                        alu_op = ALU_SLL;
                        legal  = (funct6 == FUNCT7_BASE[6:1]);
                    end
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: begin
                        // 6-bit shamt leaves funct6 to pick the shift kind.
                        alu_op = funct6[4] ? ALU_SRA : ALU_SRL;
                        legal  = (funct6 == FUNCT7_BASE[6:1]) ||
                                 (funct6 == FUNCT7_ALT[6:1]);
                    end
                    F3_OR:      alu_op = ALU_OR;
                    default:    alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
                legal   = 1'b1;
                rs1_sel = '0;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Outputs.
    // ------------------------------------------------------------------
    assign rf.addr_1 = rs1_sel;
    assign rf.addr_2 = rs2;

    assign uop.valid   = i_instr_valid & legal;
    assign uop.illegal = i_instr_valid & ~legal;
    assign uop.alu_op  = alu_op;
    assign uop.use_imm = use_imm;
    assign uop.imm     = imm;
    assign uop.rd      = rd;

endmodule

`default_nettype wire

// File: design/rv_exec_core.sv
`default_nettype none

module rv_exec_core (
    input  logic        clk,
    input  logic        arst,

    // Instruction input.
    input  logic [31:0] i_instr,
    input  logic        i_instr_valid,

    // Retire trace.
    output logic        o_wb_valid,
    output logic        o_illegal,
    output logic [4:0]  o_wb_rd,
    output logic [63:0] o_wb_data,

    // Status.
    output logic        o_a0_lsb
);

    // ------------------------------------------------------------------
    // Internal buses.
    // ------------------------------------------------------------------
    rv_regfile_if rf_if ();
    rv_uop_if     uop_if ();

    // ------------------------------------------------------------------
    // Decode and operand read.
    // ------------------------------------------------------------------
    rv_decoder u_decoder (
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .rf            (rf_if),
        .uop           (uop_if)
    );

    rv_register_file u_register_file (
        .clk      (clk),
        .arst     (arst),
        .rf       (rf_if),
        .o_a0_lsb (o_a0_lsb)
    );

    // ------------------------------------------------------------------
    // Execute and writeback.
    // ------------------------------------------------------------------
    rv_execute_unit u_execute_unit (
        .clk        (clk),
        .arst       (arst),
        .uop        (uop_if),
        .rf         (rf_if),
        .o_wb_valid (o_wb_valid),
        .o_illegal  (o_illegal),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

endmodule

`default_nettype wire

// File: design/rv_execute_unit.sv
`default_nettype none

module rv_execute_unit (
    input  logic                  clk,
    input  logic                  arst,
    rv_uop_if.execute             uop,
    rv_regfile_if.writer          rf,
    output logic                  o_wb_valid,
    output logic                  o_illegal,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output rv_core_pkg::xlen_t    o_wb_data
);
    import rv_core_pkg::*;

    // ------------------------------------------------------------------
    // Operands.
    // ------------------------------------------------------------------
    xlen_t      operand_a;
    xlen_t      operand_b;
    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    xlen_t      alu_result;

    assign operand_a = rf.read_data_1;
    assign operand_b = uop.use_imm ? uop.imm : rf.read_data_2;

    // RV64 shifts use six bits.
    assign shamt = operand_b[5:0];

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    // ------------------------------------------------------------------
    // ALU.
    // ------------------------------------------------------------------
    always_comb begin
        case (uop.alu_op)
            ALU_ADD:    alu_result = operand_a + operand_b;
            ALU_SUB:    alu_result = operand_a - operand_b;
            ALU_SLL:    alu_result = operand_a << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    alu_result = operand_a ^ operand_b;
            ALU_SRL:    alu_result = operand_a >> shamt;
            ALU_SRA:    alu_result = xlen_t'($signed(operand_a) >>> shamt);
            ALU_OR:     alu_result = operand_a | operand_b;
            ALU_AND:    alu_result = operand_a & operand_b;
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Register write, same cycle as decode.
    // ------------------------------------------------------------------
    // x0 writes go through; the register file discards them.
    assign rf.addr_3       = uop.rd;
    assign rf.write_data_3 = alu_result;
    assign rf.write_en_3   = uop.valid;

    // ------------------------------------------------------------------
    // Retire trace.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
            o_wb_rd    <= '0;
            o_wb_data  <= '0;
        end else begin
            o_wb_valid <= uop.valid;
            o_illegal  <= uop.illegal;
            if (uop.valid) begin
                o_wb_rd   <= uop.rd;
                o_wb_data <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rv_regfile_if.sv
`default_nettype none

interface rv_regfile_if;
    import rv_core_pkg::*;

    // Read ports.
    reg_addr_t addr_1;
    reg_addr_t addr_2;
    xlen_t     read_data_1;
    xlen_t     read_data_2;

    // Write port.
    reg_addr_t addr_3;
    xlen_t     write_data_3;
    logic      write_en_3;

    modport regfile (
        input  addr_1, addr_2, addr_3, write_data_3, write_en_3,
        output read_data_1, read_data_2
    );

    modport decoder (
        output addr_1, addr_2
    );

    // The execute unit consumes the operands and drives the write port.
    modport writer (
        input  read_data_1, read_data_2,
        output addr_3, write_data_3, write_en_3
    );

endinterface

`default_nettype wire

// File: design/rv_register_file.sv
`default_nettype none

module rv_register_file (
    input  logic                 clk,
    input  logic                 arst,
    rv_regfile_if.regfile        rf,
    output logic                 o_a0_lsb
);
    import rv_core_pkg::*;

    xlen_t regs [REG_COUNT];

    // ------------------------------------------------------------------
    // Write port.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.write_en_3) begin
            regs[rf.addr_3] <= rf.write_data_3;
            // x0 wins over any write that targets it.
            regs[0]         <= '0;
        end
    end

    // ------------------------------------------------------------------
    // Read ports.
    // ------------------------------------------------------------------
    // Combinational, so a write lands before the next cycle's read.
    assign rf.read_data_1 = regs[rf.addr_1];
    assign rf.read_data_2 = regs[rf.addr_2];

    // Status pin.
    assign o_a0_lsb = regs[A0_INDEX][0];

endmodule

`default_nettype wire

// File: design/rv_uop_if.sv
`default_nettype none

interface rv_uop_if;
    import rv_core_pkg::*;

    logic      valid;
    logic      illegal;
    alu_op_e   alu_op;
    logic      use_imm;
    xlen_t     imm;
    reg_addr_t rd;

    modport decoder (
        output valid, illegal, alu_op, use_imm, imm, rd
    );

    modport execute (
        input  valid, illegal, alu_op, use_imm, imm, rd
    );

endinterface

`default_nettype wire

// File: testbench/tb_rv_exec_core.sv
`default_nettype none

module tb_rv_exec_core;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 3;
    localparam int NUM_INSTR      = 2000;
    localparam int RETIRE_TIMEOUT = 20;
    localparam int RANDOM_SEED    = 16050;

    logic        clk;
    logic        arst;
    logic [31:0] i_instr;
    logic        i_instr_valid;
    logic        o_wb_valid;
    logic        o_illegal;
    logic [4:0]  o_wb_rd;
    logic [63:0] o_wb_data;
    logic        o_a0_lsb;

    // One expected retire cycle.
    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        a0_lsb;
    } retire_t;

    logic [63:0] model_regs [32];
    retire_t     expected_q [$];
    int          error_count;
    int          timeout_count;

    rv_exec_core DUT (
        .clk           (clk),
        .arst          (arst),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .o_wb_valid    (o_wb_valid),
        .o_illegal     (o_illegal),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_a0_lsb      (o_a0_lsb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model.
    // ------------------------------------------------------------------
    // Operation index order is ADD SUB SLL SLT SLTU XOR SRL SRA OR AND.
    function automatic logic [63:0] reference_alu(input int op, input logic [63:0] a,
                                                  input logic [63:0] b);
        logic [63:0] sign_flip;
        logic [5:0]  sh;
        sign_flip = 64'h8000_0000_0000_0000;
        sh        = b[5:0];
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a << sh;
            3: return {63'b0, (a ^ sign_flip) < (b ^ sign_flip)};
            4: return {63'b0, a < b};
            5: return a ^ b;
            6: return a >> sh;
            // Logical shift, then fill the vacated bits with the sign.
            7: return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'b0);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] op_funct3(input int op);
        case (op)
            0, 1: return 3'b000;
            2: return 3'b001;
            3: return 3'b010;
            4: return 3'b011;
            5: return 3'b100;
            6, 7: return 3'b101;
            8: return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] encode_op(input logic [6:0] funct7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3,
                                              input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] illegal_word();
        logic [31:0] word;
        word = $urandom;
        case ($urandom_range(2))
            0: begin
                // Major opcodes outside the supported set.
                case ($urandom_range(4))
                    0: word[6:0] = 7'b0000011;
                    1: word[6:0] = 7'b0100011;
                    2: word[6:0] = 7'b1100011;
                    3: word[6:0] = 7'b0111011;
                    default: word[6:0] = 7'b1101111;
                endcase
            end
            1: begin
                // OP with a multiply-style funct7.
                word[31:25] = 7'b0000001;
                word[6:0]   = 7'b0110011;
            end
            default: begin
                word[31:26] = 6'b000001;
                word[14:12] = 3'b101;
                word[6:0]   = 7'b0010011;
            end
        endcase
        return word;
    endfunction

    function automatic retire_t idle_item();
        retire_t item;
        item        = '0;
        item.a0_lsb = model_regs[10][0];
        return item;
    endfunction

    // Builds a random instruction and updates the model registers.
    task automatic random_instr(output logic [31:0] word, output retire_t item);
        int          pick;
        int          op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [5:0]  shamt;
        logic [63:0] operand_b;
        logic [63:0] result;
        rd    = 5'($urandom);
        rs1   = 5'($urandom);
        rs2   = 5'($urandom);
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        shamt = 6'($urandom_range(63));
        item  = '0;
        if ($urandom_range(99) < 5) begin
            word         = illegal_word();
            item.illegal = 1'b1;
        end else begin
            pick = $urandom_range(19);
            if (pick < 10) begin
                op     = pick;
                word   = encode_op((op == 1 || op == 7) ? 7'b0100000 : 7'b0000000,
                                   rs2, rs1, op_funct3(op), rd);
                result = reference_alu(op, model_regs[rs1], model_regs[rs2]);
            end else if (pick == 11) begin
                word   = {imm20, rd, 7'b0110111};
                result = {{32{imm20[19]}}, imm20, 12'b0};
            end else begin
                op = pick - 10;
                if (op == 2 || op == 6 || op == 7) begin
                    imm12     = {(op == 7) ? 6'b010000 : 6'b000000, shamt};
                    operand_b = {58'b0, shamt};
                end else begin
                    operand_b = {{52{imm12[11]}}, imm12};
                end
                word   = {imm12, rs1, op_funct3(op), rd, 7'b0010011};
                result = reference_alu(op, model_regs[rs1], operand_b);
            end
            item.valid = 1'b1;
            item.rd    = rd;
            item.data  = result;
            if (rd != 5'd0) begin
                model_regs[rd] = result;
            end
        end
        item.a0_lsb = model_regs[10][0];
    endtask

    // ------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            error_count++;
            $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, want);
        end
    endtask

    task automatic check_retire(input retire_t item);
        check_value("o_wb_valid", 64'(o_wb_valid), 64'(item.valid));
        check_value("o_illegal", 64'(o_illegal), 64'(item.illegal));
        if (item.valid) begin
            check_value("o_wb_rd", 64'(o_wb_rd), 64'(item.rd));
            check_value("o_wb_data", o_wb_data, item.data);
        end
        check_value("o_a0_lsb", 64'(o_a0_lsb), 64'(item.a0_lsb));
    endtask

    // Issues one instruction alone and waits for its retire pulse.
    task automatic issue_and_wait(input logic [31:0] word, input retire_t item);
        int   waited;
        logic seen;
        @(posedge clk);
        i_instr       <= word;
        i_instr_valid <= 1'b1;
        @(posedge clk);
        i_instr_valid <= 1'b0;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < RETIRE_TIMEOUT) begin
            @(negedge clk);
            seen = o_wb_valid | o_illegal;
            waited++;
        end
        assert (seen) else begin
            timeout_count++;
            $display("No retire pulse within %0d cycles for instruction 0x%h",
                     RETIRE_TIMEOUT, word);
        end
        if (seen) begin
            check_value("retire latency", 64'(waited), 64'd1);
            check_retire(item);
        end
    endtask

    // ORI x0, xN, 0 reads a register without changing any.
    task automatic read_all_registers();
        retire_t item;
        for (int i = 0; i < 32; i++) begin
            item       = idle_item();
            item.valid = 1'b1;
            item.data  = model_regs[i];
            issue_and_wait({12'h000, 5'(i), 3'b110, 5'd0, 7'b0010011}, item);
        end
    endtask

    task automatic run_random(input int count);
        logic [31:0] word;
        retire_t     item;
        int          issued;
        issued = 0;
        expected_q.push_back(idle_item());
        while (issued < count) begin
            @(posedge clk);
            if ($urandom_range(99) < 20) begin
                i_instr_valid <= 1'b0;
                i_instr       <= $urandom;
                item = idle_item();
            end else begin
                random_instr(word, item);
                i_instr       <= word;
                i_instr_valid <= 1'b1;
                issued++;
            end
            expected_q.push_back(item);
            // Outputs now show the previous cycle's instruction.
            @(negedge clk);
            check_retire(expected_q.pop_front());
        end
        @(posedge clk);
        i_instr_valid <= 1'b0;
        @(negedge clk);
        check_retire(expected_q.pop_front());
    endtask

    // ------------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------------
    initial begin
        retire_t item;
        arst          <= 1'b1;
        i_instr       <= '0;
        i_instr_valid <= 1'b0;
        error_count   = 0;
        timeout_count = 0;
        void'($urandom(RANDOM_SEED));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst <= 1'b0;

        // Quiet outputs after reset.
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_retire(idle_item());
            check_value("o_wb_rd", 64'(o_wb_rd), 64'd0);
            check_value("o_wb_data", o_wb_data, 64'd0);
        end
        read_all_registers();

        // ADDI x0, x0, -5 reports the sum but x0 stays zero.
        item       = idle_item();
        item.valid = 1'b1;
        item.data  = 64'hFFFF_FFFF_FFFF_FFFB;
        issue_and_wait({12'hFFB, 5'd0, 3'b000, 5'd0, 7'b0010011}, item);

        run_random(NUM_INSTR);

        item         = idle_item();
        item.illegal = 1'b1;
        issue_and_wait(illegal_word(), item);
        read_all_registers();

        $display("Errors: %0d value mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
